// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

   // bus widths
   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // ram geometry, byte addresses 0..RAM_WORDS*4-1
   localparam int RAM_WORDS = 256;
   localparam int RAM_AW    = $clog2(RAM_WORDS);

   // axi response codes
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   // core side memory operations
   typedef enum logic [2:0] {
      MEM_LB  = 3'd0, // byte, sign extended
      MEM_LH  = 3'd1,
      MEM_LW  = 3'd2,
      MEM_LBU = 3'd3, // byte, zero extended
      MEM_LHU = 3'd4,
      MEM_SB  = 3'd5,
      MEM_SH  = 3'd6,
      MEM_SW  = 3'd7
   } mem_op_e;

endpackage

`default_nettype wire

// File: logic/axi_lite_if.sv
`timescale 1ns/100ps
`default_nettype none

interface axi_lite_if;
   import mem_pkg::*;

   // read address
   logic [ADDR_W-1:0] araddr;
   logic              arvalid;
   logic              arready;

   // read data
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rvalid;
   logic              rready;

   // write address
   logic [ADDR_W-1:0] awaddr;
   logic              awvalid;
   logic              awready;

   // write data
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              wvalid;
   logic              wready;

   // write response
   logic [1:0]        bresp;
   logic              bvalid;
   logic              bready;

   modport master (
      output araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
      input  arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
   );

   modport slave (
      input  araddr, arvalid, rready, awaddr, awvalid, wdata, wstrb, wvalid, bready,
      output arready, rdata, rresp, rvalid, awready, wready, bresp, bvalid
   );

endinterface

`default_nettype wire

// File: logic/axi_master.sv
`timescale 1ns/100ps
`default_nettype none

module axi_master (
   input  wire                        axi_aclk_i,
   input  wire                        axi_aresetn_i,
   input  wire                        req_valid_i,
   input  wire mem_pkg::mem_op_e      req_op_i,
   input  wire [mem_pkg::ADDR_W-1:0]  req_addr_i,
   input  wire [mem_pkg::DATA_W-1:0]  req_wdata_i,
   output logic                       stall_o,
   output logic [mem_pkg::DATA_W-1:0] load_data_o,
   output logic                       load_valid_o,
   output logic                       access_err_o,
   axi_lite_if.master                 axi_m
);
   import mem_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      READ,   // ar pending or waiting for r
      WRITE,  // aw and/or w pending
      WAIT_B
   } state_e;

   state_e            state_q;
   mem_op_e           op_q;
   logic [ADDR_W-1:0] addr_q;
   logic [DATA_W-1:0] wdata_q;
   logic [STRB_W-1:0] wstrb_q;
   logic              arvalid_q;
   logic              awvalid_q;
   logic              wvalid_q;

   logic              ar_hs;
   logic              aw_hs;
   logic              w_hs;
   logic              r_hs;
   logic              b_hs;
   logic              done;
   logic              accept;
   logic              req_is_load;
   logic [DATA_W-1:0] st_wdata;
   logic [STRB_W-1:0] st_strb;
   logic [7:0]        lane_b;
   logic [15:0]       lane_h;

   assign axi_m.araddr  = addr_q;
   assign axi_m.arvalid = arvalid_q;
   assign axi_m.rready  = (state_q == READ);
   assign axi_m.awaddr  = addr_q;
   assign axi_m.awvalid = awvalid_q;
   assign axi_m.wdata   = wdata_q;
   assign axi_m.wstrb   = wstrb_q;
   assign axi_m.wvalid  = wvalid_q;
   assign axi_m.bready  = (state_q == WAIT_B);

   assign ar_hs = axi_m.arvalid & axi_m.arready;
   assign aw_hs = axi_m.awvalid & axi_m.awready;
   assign w_hs  = axi_m.wvalid & axi_m.wready;
   assign r_hs  = axi_m.rvalid & axi_m.rready;
   assign b_hs  = axi_m.bvalid & axi_m.bready;
   assign done  = r_hs | b_hs;

   // released in the response cycle, next request can go at the following edge
   assign stall_o = (state_q != IDLE) & ~done;
   assign accept  = req_valid_i & ~stall_o;

   assign req_is_load = !(req_op_i inside {MEM_SB, MEM_SH, MEM_SW});

   assign load_valid_o = r_hs;
   assign access_err_o = (r_hs & (axi_m.rresp == RESP_SLVERR)) |
                         (b_hs & (axi_m.bresp == RESP_SLVERR));

   // store data and strobes onto the addressed lane
   always_comb begin
      st_wdata = req_wdata_i;
      st_strb  = {STRB_W{1'b1}};
      case (req_op_i)
         MEM_SB: begin
            st_wdata = DATA_W'(req_wdata_i[7:0]) << {req_addr_i[1:0], 3'b000};
            st_strb  = STRB_W'(1) << req_addr_i[1:0];
         end
         MEM_SH: begin
            st_wdata = DATA_W'(req_wdata_i[15:0]) << {req_addr_i[1], 4'b0000};
            st_strb  = STRB_W'(3) << {req_addr_i[1], 1'b0};
         end
         default: begin
         end
      endcase
   end

   // load lane select and extension
   always_comb begin
      lane_b = axi_m.rdata[{addr_q[1:0], 3'b000} +: 8];
      lane_h = axi_m.rdata[{addr_q[1], 4'b0000} +: 16];
      case (op_q)
         MEM_LB:  load_data_o = {{(DATA_W-8){lane_b[7]}}, lane_b};
         MEM_LBU: load_data_o = {{(DATA_W-8){1'b0}}, lane_b};
         MEM_LH:  load_data_o = {{(DATA_W-16){lane_h[15]}}, lane_h};
         MEM_LHU: load_data_o = {{(DATA_W-16){1'b0}}, lane_h};
         MEM_LW:  load_data_o = axi_m.rdata;
         default: load_data_o = '0;
      endcase
      if (axi_m.rresp == RESP_SLVERR) begin
         load_data_o = '0; // failed load reads as zero
      end
   end

   always_ff @(posedge axi_aclk_i) begin
      if (!axi_aresetn_i) begin
         state_q   <= IDLE;
         arvalid_q <= 1'b0;
         awvalid_q <= 1'b0;
         wvalid_q  <= 1'b0;
      end else begin
         if (ar_hs) arvalid_q <= 1'b0;
         if (aw_hs) awvalid_q <= 1'b0; // aw and w drop independently
         if (w_hs)  wvalid_q  <= 1'b0;

         case (state_q)
            WRITE: begin
               if ((aw_hs | ~awvalid_q) & (w_hs | ~wvalid_q)) begin
                  state_q <= WAIT_B;
               end
            end
            READ, WAIT_B: begin
               if (done) state_q <= IDLE;
            end
            default: begin
            end
         endcase

         if (accept) begin
            state_q   <= req_is_load ? READ : WRITE;
            arvalid_q <= req_is_load;
            awvalid_q <= ~req_is_load;
            wvalid_q  <= ~req_is_load;
         end
      end
   end

   always_ff @(posedge axi_aclk_i) begin
      if (accept) begin
         op_q    <= req_op_i;
         addr_q  <= req_addr_i;
         wdata_q <= st_wdata;
         wstrb_q <= st_strb;
      end
   end

   a_ar_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
      axi_m.arvalid && !axi_m.arready |=> axi_m.arvalid && $stable(axi_m.araddr));

   a_aw_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
      axi_m.awvalid && !axi_m.awready |=> axi_m.awvalid && $stable(axi_m.awaddr));

   // misaligned accesses are not split
   a_half_align: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
      accept && (req_op_i inside {MEM_LH, MEM_LHU, MEM_SH}) |-> !req_addr_i[0]);

   a_word_align: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
      accept && (req_op_i inside {MEM_LW, MEM_SW}) |-> req_addr_i[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: logic/axi_ram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_ram (
   input  wire       axi_aclk_i,
   input  wire       axi_aresetn_i,
   axi_lite_if.slave axi_s
);
   import mem_pkg::*;

   logic [DATA_W-1:0] mem [RAM_WORDS];

   logic              ar_rdy_q;
   logic              wr_rdy_q;
   logic              rd_pend_q;
   logic              wr_pend_q;
   logic              rvalid_q;
   logic              bvalid_q;
   logic [ADDR_W-1:0] rd_addr_q;
   logic [DATA_W-1:0] rdata_q;
   logic [1:0]        rresp_q;
   logic [1:0]        bresp_q;

   logic              ar_hs;
   logic              wr_hs;
   logic              r_hs;
   logic              b_hs;
   logic              wr_in_range;
   logic              rd_in_range;
   logic [RAM_AW-1:0] wr_idx;
   logic [RAM_AW-1:0] rd_idx;

   // address and data are taken in the same beat
   assign wr_hs = wr_rdy_q & axi_s.awvalid & axi_s.wvalid;
   assign ar_hs = axi_s.arvalid & ar_rdy_q;
   assign r_hs  = rvalid_q & axi_s.rready;
   assign b_hs  = bvalid_q & axi_s.bready;

   assign axi_s.arready = ar_rdy_q;
   assign axi_s.awready = wr_hs;
   assign axi_s.wready  = wr_hs;
   assign axi_s.rvalid  = rvalid_q;
   assign axi_s.rdata   = rdata_q;
   assign axi_s.rresp   = rresp_q;
   assign axi_s.bvalid  = bvalid_q;
   assign axi_s.bresp   = bresp_q;

   assign wr_idx      = axi_s.awaddr[RAM_AW+1:2];
   assign wr_in_range = (axi_s.awaddr[ADDR_W-1:RAM_AW+2] == '0);
   assign rd_idx      = rd_addr_q[RAM_AW+1:2];
   assign rd_in_range = (rd_addr_q[ADDR_W-1:RAM_AW+2] == '0);

   // byte-strobed array, cleared on reset
   always_ff @(posedge axi_aclk_i) begin
      if (!axi_aresetn_i) begin
         for (int i = 0; i < RAM_WORDS; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_hs && wr_in_range) begin
         for (int b = 0; b < STRB_W; b++) begin
            if (axi_s.wstrb[b]) mem[wr_idx][8*b +: 8] <= axi_s.wdata[8*b +: 8];
         end
      end
   end

   always_ff @(posedge axi_aclk_i) begin
      if (!axi_aresetn_i) begin
         ar_rdy_q  <= 1'b0;
         wr_rdy_q  <= 1'b0;
         rd_pend_q <= 1'b0;
         wr_pend_q <= 1'b0;
         rvalid_q  <= 1'b0;
         bvalid_q  <= 1'b0;
      end else begin
         // read side, one access in flight
         if (ar_hs) begin
            ar_rdy_q <= 1'b0;
         end else if (!rd_pend_q && (!rvalid_q || axi_s.rready)) begin
            ar_rdy_q <= 1'b1;
         end
         rd_pend_q <= ar_hs;
         if (rd_pend_q) begin
            rvalid_q <= 1'b1;
         end else if (r_hs) begin
            rvalid_q <= 1'b0;
         end

         // write side
         if (wr_hs) begin
            wr_rdy_q <= 1'b0;
         end else if (!wr_pend_q && (!bvalid_q || axi_s.bready)) begin
            wr_rdy_q <= 1'b1;
         end
         wr_pend_q <= wr_hs;
         if (wr_pend_q) begin
            bvalid_q <= 1'b1;
         end else if (b_hs) begin
            bvalid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge axi_aclk_i) begin
      if (ar_hs) rd_addr_q <= axi_s.araddr;
      if (rd_pend_q) begin
         rdata_q <= rd_in_range ? mem[rd_idx] : '0;
         rresp_q <= rd_in_range ? RESP_OKAY : RESP_SLVERR;
      end
      if (wr_hs) bresp_q <= wr_in_range ? RESP_OKAY : RESP_SLVERR;
   end

   a_r_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
      axi_s.rvalid && !axi_s.rready |=> axi_s.rvalid && $stable(axi_s.rdata));

   a_b_hold: assert property (@(posedge axi_aclk_i) disable iff (!axi_aresetn_i)
      axi_s.bvalid && !axi_s.bready |=> axi_s.bvalid && $stable(axi_s.bresp));

endmodule

`default_nettype wire

// File: logic/mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top (
   input  wire                        axi_aclk_i,
   input  wire                        axi_aresetn_i,

   // core side
   input  wire                        req_valid_i,
   input  wire mem_pkg::mem_op_e      req_op_i,
   input  wire [mem_pkg::ADDR_W-1:0]  req_addr_i,
   input  wire [mem_pkg::DATA_W-1:0]  req_wdata_i,
   output logic                       stall_o,
   output logic [mem_pkg::DATA_W-1:0] load_data_o,
   output logic                       load_valid_o,
   output logic                       access_err_o
);

   axi_lite_if axi_bus ();

   // core request to axi4-lite
   axi_master u_master (
      .axi_aclk_i    (axi_aclk_i),
      .axi_aresetn_i (axi_aresetn_i),
      .req_valid_i   (req_valid_i),
      .req_op_i      (req_op_i),
      .req_addr_i    (req_addr_i),
      .req_wdata_i   (req_wdata_i),
      .stall_o       (stall_o),
      .load_data_o   (load_data_o),
      .load_valid_o  (load_valid_o),
      .access_err_o  (access_err_o),
      .axi_m         (axi_bus.master)
   );

   axi_ram u_ram (
      .axi_aclk_i    (axi_aclk_i),
      .axi_aresetn_i (axi_aresetn_i),
      .axi_s         (axi_bus.slave)
   );

endmodule

`default_nettype wire

// File: dv/tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;
   import mem_pkg::*;

   localparam int          WAIT_LIMIT  = 50;  // cycles per wait loop
   localparam int          NUM_RANDOM  = 500;
   localparam int          MODEL_BYTES = 1024;
   localparam logic [31:0] SEED        = 32'h7cfacd5c;

   logic              axi_aclk = 1'b0;
   logic              axi_aresetn;
   logic              req_valid;
   mem_op_e           req_op;
   logic [ADDR_W-1:0] req_addr;
   logic [DATA_W-1:0] req_wdata;
   logic              stall;
   logic [DATA_W-1:0] load_data;
   logic              load_valid;
   logic              access_err;

   logic [7:0]  model_mem [MODEL_BYTES]; // byte image of the ram
   int          errors;
   int          timeouts;
   int          issued;
   int          completed;
   logic        timed_out;
   logic        stall_prev;

   always #20 axi_aclk = ~axi_aclk;

   mem_subsys_top DUT (
      .axi_aclk_i    (axi_aclk),
      .axi_aresetn_i (axi_aresetn),
      .req_valid_i   (req_valid),
      .req_op_i      (req_op),
      .req_addr_i    (req_addr),
      .req_wdata_i   (req_wdata),
      .stall_o       (stall),
      .load_data_o   (load_data),
      .load_valid_o  (load_valid),
      .access_err_o  (access_err)
   );

   // one completion per release of stall_o
   always @(negedge axi_aclk) begin
      if (axi_aresetn && stall_prev && !stall) begin
         completed++;
      end
      stall_prev = stall;
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
         errors++;
      end
   endtask

   // little endian view of the model, extended by op
   function automatic logic [31:0] model_load(input mem_op_e op, input logic [31:0] addr);
      logic [9:0]  a;
      logic [7:0]  b;
      logic [15:0] h;
      logic [31:0] w;
      if (addr >= 32'(MODEL_BYTES)) return '0;
      a = addr[9:0];
      b = model_mem[a];
      h = {model_mem[a + 10'd1], model_mem[a]};
      w = {model_mem[a + 10'd3], model_mem[a + 10'd2], model_mem[a + 10'd1], model_mem[a]};
      case (op)
         MEM_LB:  return {{24{b[7]}}, b};
         MEM_LBU: return {24'd0, b};
         MEM_LH:  return {{16{h[15]}}, h};
         MEM_LHU: return {16'd0, h};
         MEM_LW:  return w;
         default: return '0;
      endcase
   endfunction

   function automatic void model_store(input mem_op_e op, input logic [31:0] addr,
                                       input logic [31:0] wdata);
      logic [9:0] a;
      if (addr >= 32'(MODEL_BYTES)) return; // out of range, nothing written
      a = addr[9:0];
      model_mem[a] = wdata[7:0];
      if (op == MEM_SH || op == MEM_SW) model_mem[a + 10'd1] = wdata[15:8];
      if (op == MEM_SW) begin
         model_mem[a + 10'd2] = wdata[23:16];
         model_mem[a + 10'd3] = wdata[31:24];
      end
   endfunction

   function automatic mem_op_e rand_op();
      logic [31:0] r;
      r = $urandom;
      return mem_op_e'(r[2:0]);
   endfunction

   // about one in eight lands in 1024..1279
   function automatic logic [31:0] rand_addr(input mem_op_e op);
      logic [31:0] a;
      if ($urandom_range(7, 0) == 0) a = 32'd1024 + ($urandom % 32'd256);
      else a = $urandom % 32'(MODEL_BYTES);
      if (op inside {MEM_LH, MEM_LHU, MEM_SH}) a[0] = 1'b0;
      if (op inside {MEM_LW, MEM_SW}) a[1:0] = 2'b00;
      return a;
   endfunction

   // one request, called and left on a falling edge
   task automatic do_access(input mem_op_e op, input logic [31:0] addr,
                            input logic [31:0] wdata);
      int          wait_cnt;
      logic        is_load;
      logic        exp_err;
      logic [31:0] exp_data;
      is_load  = !(op inside {MEM_SB, MEM_SH, MEM_SW});
      exp_err  = (addr >= 32'(MODEL_BYTES));
      exp_data = model_load(op, addr);

      wait_cnt = 0;
      while (stall && wait_cnt < WAIT_LIMIT) begin
         @(negedge axi_aclk);
         wait_cnt++;
      end
      if (stall) begin
         $display("timeout: stall_o stayed high before a new request");
         timeouts++;
         timed_out = 1'b1;
         return;
      end

      req_valid = 1'b1;
      req_op    = op;
      req_addr  = addr;
      req_wdata = wdata;
      issued++;
      @(negedge axi_aclk);
      req_valid = 1'b0;

      wait_cnt = 0;
      while (!(is_load ? load_valid : !stall) && wait_cnt < WAIT_LIMIT) begin
         @(negedge axi_aclk);
         wait_cnt++;
      end
      if (!(is_load ? load_valid : !stall)) begin
         $display("timeout: access %s at address 0x%08h never completed", op.name(), addr);
         timeouts++;
         timed_out = 1'b1;
         return;
      end

      check_value("access_err_o", 32'(access_err), 32'(exp_err));
      if (is_load) begin
         check_value("load_data_o", load_data, exp_data);
      end else begin
         check_value("load_valid_o", 32'(load_valid), 32'd0);
         model_store(op, addr, wdata);
      end
   endtask

   initial begin
      mem_op_e     op;
      logic [31:0] addr;
      logic [31:0] data;

      void'($urandom(SEED));
      axi_aresetn = 1'b0;
      req_valid   = 1'b0;
      req_op      = MEM_LW;
      req_addr    = '0;
      req_wdata   = '0;
      errors      = 0;
      timeouts    = 0;
      issued      = 0;
      completed   = 0;
      timed_out   = 1'b0;
      for (int i = 0; i < MODEL_BYTES; i++) model_mem[i] = 8'h00;

      repeat (16) @(negedge axi_aclk);
      axi_aresetn = 1'b1;
      @(negedge axi_aclk);

      // idle after reset, ram reads back zero
      check_value("stall_o", 32'(stall), 32'd0);
      check_value("load_valid_o", 32'(load_valid), 32'd0);
      check_value("access_err_o", 32'(access_err), 32'd0);
      for (int n = 0; n < 8 && !timed_out; n++) begin
         do_access(MEM_LW, rand_addr(MEM_LW) % 32'(MODEL_BYTES), '0);
      end

      // store then load of the same spot
      for (int n = 0; n < 8 && !timed_out; n++) begin
         addr = ($urandom % 32'(MODEL_BYTES)) & ~32'd3;
         do_access(MEM_SW, addr, $urandom);
         do_access(MEM_LW, addr, '0);
         do_access(MEM_SB, addr + 32'(n % 4), $urandom);
         do_access(MEM_LW, addr, '0);
         do_access(MEM_SH, addr + 32'((n % 2) * 2), $urandom);
         do_access(MEM_LW, addr, '0);
         do_access(MEM_LB, addr + 32'(n % 4), '0);
         do_access(MEM_LHU, addr + 32'((n % 2) * 2), '0);
      end

      // out-of-range store must not alias onto the low words
      for (int n = 0; n < 8 && !timed_out; n++) begin
         addr = ($urandom % 32'(MODEL_BYTES)) & ~32'd3;
         do_access(MEM_SW, addr + 32'd1024, $urandom);
         do_access(MEM_LW, addr + 32'd1024, '0);
         do_access(MEM_LW, addr, '0);
      end

      for (int n = 0; n < NUM_RANDOM && !timed_out; n++) begin
         op   = rand_op();
         addr = rand_addr(op);
         data = $urandom;
         do_access(op, addr, data);
         if (op inside {MEM_SB, MEM_SH, MEM_SW} && !timed_out) begin
            do_access(MEM_LW, {addr[31:2], 2'b00}, '0); // whole word after a store
         end
      end

      @(negedge axi_aclk); // let the last release be counted
      check_value("completions", 32'(completed), 32'(issued));
      $display("run ended: %0d mismatches, %0d timeouts, %0d requests, %0d completions",
               errors, timeouts, issued, completed);
      if (errors == 0 && timeouts == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: sim.f
logic/mem_pkg.sv
logic/axi_lite_if.sv
logic/axi_master.sv
logic/axi_ram.sv
logic/mem_subsys_top.sv
dv/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/100ps \
   -f sim.f --top-module tb_mem_subsys \
   --Mdir obj_dir -o tb_mem_subsys \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_mem_subsys > "$LOG" 2>&1 || { cat "$LOG"; echo "simulator exited with an error"; exit 1; }

cat "$LOG"
grep -q "Verification failed" "$LOG" && exit 1 || exit 0
